// File: dv/mem_stage_tb.sv
`timescale 1ns/1ps

module mem_stage_tb import mem_stage_pkg::*; ();

    localparam int N_IDLE  = 4;
    localparam int N_FILL  = BANK_DEPTH;
    localparam int N_WLOAD = 64;
    localparam int N_BH    = 48;
    localparam int N_RW    = 32;
    localparam int N_COL   = 16;
    localparam int N_MIX   = 400;
    localparam int N_DRAIN = 4;
    localparam int N_OPS   = N_IDLE + N_FILL + N_WLOAD + 2 * N_BH + N_RW + 2 * N_COL
                             + N_MIX + N_DRAIN;
    localparam int CYCLE_LIMIT = 3 * N_OPS + 50;

    logic                 CLK = 1'b0;
    logic                 reset;
    logic [REG_IDX_W-1:0] exec_reg_w_rd;
    logic [XLEN-1:0]      exec_reg_w_data;
    logic                 exec_mem_r_valid;
    logic [REG_IDX_W-1:0] exec_mem_r_rd;
    logic [ADDR_W-1:0]    exec_mem_r_addr;
    logic [LANES-1:0]     exec_mem_r_strb;
    logic                 exec_mem_r_signed;
    logic                 exec_mem_w_valid;
    logic [ADDR_W-1:0]    exec_mem_w_addr;
    logic [LANES-1:0]     exec_mem_w_strb;
    logic [XLEN-1:0]      exec_mem_w_data;
    logic                 wb_valid;
    logic [REG_IDX_W-1:0] wb_rd;
    logic [XLEN-1:0]      wb_data;

    // Reference memory covers the 1 KB that the banks address.
    logic [7:0]           model_mem [1024];
    int                   exp_due[$];
    logic [REG_IDX_W-1:0] exp_rd[$];
    logic [XLEN-1:0]      exp_data[$];

    int                   cyc;
    int                   cycle_cnt = 0;
    logic [ADDR_W-1:0]    addr;
    logic [ADDR_W-1:0]    addr2;
    logic [LANES-1:0]     strb;
    logic [LANES-1:0]     strb2;
    logic [REG_IDX_W-1:0] rd;
    logic                 sgn;
    logic [7:0]           widx;
    int                   kind;

    mem_stage_top u_mem_stage_top (
        .CLK               (CLK),
        .reset             (reset),
        .exec_reg_w_rd     (exec_reg_w_rd),
        .exec_reg_w_data   (exec_reg_w_data),
        .exec_mem_r_valid  (exec_mem_r_valid),
        .exec_mem_r_rd     (exec_mem_r_rd),
        .exec_mem_r_addr   (exec_mem_r_addr),
        .exec_mem_r_strb   (exec_mem_r_strb),
        .exec_mem_r_signed (exec_mem_r_signed),
        .exec_mem_w_valid  (exec_mem_w_valid),
        .exec_mem_w_addr   (exec_mem_w_addr),
        .exec_mem_w_strb   (exec_mem_w_strb),
        .exec_mem_w_data   (exec_mem_w_data),
        .wb_valid          (wb_valid),
        .wb_rd             (wb_rd),
        .wb_data           (wb_data)
    );

    always #5 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > CYCLE_LIMIT) begin
            $display("Simulation failed");
            $fatal(1, "Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s (got %h, expected %h)",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [9:0] a);
        return {a, 6'h15, ~a, a[5:0]} ^ 32'h3c5a_a5c3;
    endfunction

    function automatic logic [REG_IDX_W-1:0] rand_rd();
        return REG_IDX_W'($urandom_range(31, 1));
    endfunction

    // Little-endian read of an aligned byte, halfword or word from the model.
    function automatic logic [31:0] model_load(input logic [31:0] a_full,
                                               input logic [3:0] s, input logic sg);
        logic [9:0]  a;
        logic [7:0]  b;
        logic [15:0] h;
        int          nbytes;
        a = a_full[9:0];
        nbytes = 0;
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                nbytes++;
            end
        end
        b = model_mem[a];
        h = {model_mem[{a[9:1], 1'b1}], model_mem[{a[9:1], 1'b0}]};
        if (nbytes == 1) begin
            return {{24{sg & b[7]}}, b};
        end else if (nbytes == 2) begin
            return {{16{sg & h[15]}}, h};
        end
        return {model_mem[{a[9:2], 2'd3}], model_mem[{a[9:2], 2'd2}],
                model_mem[{a[9:2], 2'd1}], model_mem[{a[9:2], 2'd0}]};
    endfunction

    // Store data sits in the low bytes and lands from the addressed lane upwards.
    task automatic model_store(input logic [31:0] a, input logic [3:0] s,
                               input logic [31:0] d);
        int off;
        int k;
        off = int'(a[1:0]);
        for (int i = 0; i < 4; i++) begin
            if (s[i]) begin
                k = i - off;
                model_mem[{a[9:2], 2'(i)}] = d[k*8 +: 8];
            end
        end
    endtask

    // Random aligned access of a given size; address bits above 1 KB are noise.
    task automatic pick_access(input int size, input logic [7:0] w,
                               output logic [ADDR_W-1:0] a, output logic [3:0] s);
        int off;
        case (size)
            0:       off = $urandom_range(3, 0);
            1:       off = 2 * $urandom_range(1, 0);
            default: off = 0;
        endcase
        a = {22'($urandom), w, 2'(off)};
        case (size)
            0:       s = 4'b0001 << off;
            1:       s = 4'b0011 << off;
            default: s = 4'b1111;
        endcase
    endtask

    task automatic set_idle();
        exec_reg_w_rd     = '0;
        exec_reg_w_data   = '0;
        exec_mem_r_valid  = 1'b0;
        exec_mem_r_rd     = '0;
        exec_mem_r_addr   = '0;
        exec_mem_r_strb   = '0;
        exec_mem_r_signed = 1'b0;
        exec_mem_w_valid  = 1'b0;
        exec_mem_w_addr   = '0;
        exec_mem_w_strb   = '0;
        exec_mem_w_data   = '0;
    endtask

    task automatic drive_store(input logic [ADDR_W-1:0] a, input logic [3:0] s,
                               input logic [31:0] d);
        exec_mem_w_valid = 1'b1;
        exec_mem_w_addr  = a;
        exec_mem_w_strb  = s;
        exec_mem_w_data  = d;
    endtask

    task automatic drive_load(input logic [REG_IDX_W-1:0] r, input logic [ADDR_W-1:0] a,
                              input logic [3:0] s, input logic sg);
        exec_mem_r_valid  = 1'b1;
        exec_mem_r_rd     = r;
        exec_mem_r_addr   = a;
        exec_mem_r_strb   = s;
        exec_mem_r_signed = sg;
    endtask

    task automatic drive_reg_write(input logic [REG_IDX_W-1:0] r, input logic [31:0] d);
        exec_reg_w_rd   = r;
        exec_reg_w_data = d;
    endtask

    // The load is evaluated before this cycle's store, so a collision sees old bytes.
    task automatic record_issue();
        if (exec_mem_r_valid) begin
            exp_due.push_back(cyc + 2);
            exp_rd.push_back(exec_mem_r_rd);
            exp_data.push_back(model_load(exec_mem_r_addr, exec_mem_r_strb,
                                          exec_mem_r_signed));
        end else if (exec_reg_w_rd != '0) begin
            exp_due.push_back(cyc + 2);
            exp_rd.push_back(exec_reg_w_rd);
            exp_data.push_back(exec_reg_w_data);
        end
        if (exec_mem_w_valid) begin
            model_store(exec_mem_w_addr, exec_mem_w_strb, exec_mem_w_data);
        end
    endtask

    task automatic check_writeback();
        if (exp_due.size() != 0 && exp_due[0] == cyc) begin
            compare(32'(wb_valid), 32'd1, "expected writeback is missing");
            compare(32'(wb_rd), 32'(exp_rd[0]), "writeback register index");
            compare(wb_data, exp_data[0], "writeback data");
            void'(exp_due.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
        end else begin
            compare(32'(wb_valid), 32'd0, "writeback without a request");
        end
    endtask

    task automatic next_cycle();
        @(negedge CLK);
        cyc++;
        check_writeback();
        set_idle();
    endtask

    initial begin
        void'($urandom(89));
        reset = 1'b1;
        cyc   = 0;
        set_idle();
        // Loads and register writes offered during reset must never reach the writeback.
        repeat (8) begin
            @(negedge CLK);
            compare(32'(wb_valid), 32'd0, "wb_valid during reset");
            pick_access(2, 8'($urandom), addr, strb);
            drive_load(rand_rd(), addr, strb, 1'($urandom));
            drive_reg_write(rand_rd(), $urandom);
        end
        set_idle();
        reset = 1'b0;

        repeat (N_IDLE) next_cycle();

        // Every word gets a known value first.
        for (int n = 0; n < N_FILL; n++) begin
            next_cycle();
            addr = {22'($urandom), 8'(n), 2'b00};
            drive_store(addr, 4'b1111, fill_word(addr[9:0]));
            record_issue();
        end

        for (int n = 0; n < N_WLOAD; n++) begin
            next_cycle();
            pick_access(2, 8'($urandom), addr, strb);
            drive_load(rand_rd(), addr, strb, 1'($urandom));
            record_issue();
        end

        // Narrow stores, each followed by a narrow load inside the same word.
        for (int n = 0; n < N_BH; n++) begin
            widx = 8'($urandom);
            next_cycle();
            pick_access($urandom_range(1, 0), widx, addr, strb);
            drive_store(addr, strb, $urandom);
            record_issue();
            next_cycle();
            pick_access($urandom_range(1, 0), widx, addr, strb);
            drive_load(rand_rd(), addr, strb, 1'($urandom));
            record_issue();
        end

        for (int n = 0; n < N_RW; n++) begin
            next_cycle();
            rd = (n % 4 == 0) ? '0 : rand_rd();
            drive_reg_write(rd, $urandom);
            record_issue();
        end

        // Load together with a store to the same word, then again one cycle later.
        for (int n = 0; n < N_COL; n++) begin
            widx = 8'($urandom);
            rd   = rand_rd();
            sgn  = 1'($urandom);
            next_cycle();
            pick_access(2, widx, addr, strb);
            pick_access($urandom_range(2, 0), widx, addr2, strb2);
            drive_store(addr, strb, $urandom);
            drive_load(rd, addr2, strb2, sgn);
            record_issue();
            next_cycle();
            drive_load(rd, addr2, strb2, sgn);
            record_issue();
        end

        // A small address window keeps stores and loads hitting the same words.
        for (int n = 0; n < N_MIX; n++) begin
            next_cycle();
            kind = $urandom_range(5, 0);
            if (kind <= 1 || kind == 4) begin
                pick_access($urandom_range(2, 0), 8'($urandom_range(15, 0)), addr, strb);
                drive_load(rand_rd(), addr, strb, 1'($urandom));
            end
            if (kind == 2 || kind == 4) begin
                drive_reg_write(rand_rd(), $urandom);
            end else if (kind == 3) begin
                drive_reg_write('0, $urandom);
            end
            if ($urandom_range(1, 0) == 1) begin
                pick_access($urandom_range(2, 0), 8'($urandom_range(15, 0)), addr, strb);
                drive_store(addr, strb, $urandom);
            end
            record_issue();
        end

        repeat (N_DRAIN) next_cycle();

        if (exp_due.size() != 0) begin
            $display("Simulation failed");
            $fatal(1, "%0d expected writebacks never arrived", exp_due.size());
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

// File: hdl/byte_lane_ram.sv
`timescale 1ns/1ps

module byte_lane_ram import mem_stage_pkg::*; (
    input  logic      CLK,
    bank_port_if.sink port
);

    logic [BYTE_W-1:0] mem [BANK_DEPTH];

    always_ff @(posedge CLK) begin
        if (port.we) begin
            mem[port.waddr] <= port.wdata;
        end
    end

    // A read to the word being written returns the byte from before the write.
    always_ff @(posedge CLK) begin
        if (port.re) begin
            port.rdata <= mem[port.raddr];
        end
    end

endmodule

// File: hdl/cushion.sv
`timescale 1ns/1ps

module cushion import mem_stage_pkg::*; (
    input  logic                 CLK,
    input  logic                 reset,

    // Register write from the execute unit.
    input  logic [REG_IDX_W-1:0] exec_reg_w_rd,
    input  logic [XLEN-1:0]      exec_reg_w_data,

    // Load request from the execute unit.
    input  logic                 exec_mem_r_valid,
    input  logic [REG_IDX_W-1:0] exec_mem_r_rd,
    input  logic [ADDR_W-1:0]    exec_mem_r_addr,
    input  logic [LANES-1:0]     exec_mem_r_strb,
    input  logic                 exec_mem_r_signed,

    // Store request from the execute unit.
    input  logic                 exec_mem_w_valid,
    input  logic [ADDR_W-1:0]    exec_mem_w_addr,
    input  logic [LANES-1:0]     exec_mem_w_strb,
    input  logic [XLEN-1:0]      exec_mem_w_data,

    // Towards the memory access logic.
    output logic [REG_IDX_W-1:0] reg_w_rd,
    output logic [XLEN-1:0]      reg_w_data,
    mem_rd_if.source             rd_req,
    mem_wr_if.source             wr_req
);

    // Strobes and the destination index.
    always_ff @(posedge CLK) begin
        if (reset) begin
            reg_w_rd     <= '0;
            rd_req.valid <= 1'b0;
            wr_req.valid <= 1'b0;
        end else begin
            reg_w_rd     <= exec_reg_w_rd;
            rd_req.valid <= exec_mem_r_valid;
            wr_req.valid <= exec_mem_w_valid;
        end
    end

    // Payload of all three groups.
    always_ff @(posedge CLK) begin
        reg_w_data       <= exec_reg_w_data;

        rd_req.rd        <= exec_mem_r_rd;
        rd_req.addr      <= exec_mem_r_addr;
        rd_req.strb      <= exec_mem_r_strb;
        rd_req.signed_ld <= exec_mem_r_signed;

        wr_req.addr      <= exec_mem_w_addr;
        wr_req.strb      <= exec_mem_w_strb;
        wr_req.data      <= exec_mem_w_data;
    end

endmodule

// File: hdl/load_align.sv
`timescale 1ns/1ps

module load_align import mem_stage_pkg::*; (
    input  logic                 CLK,
    input  logic                 reset,
    mem_rd_if.sink               rd_req,
    bank_port_if.tap             bank [LANES],
    input  logic [REG_IDX_W-1:0] reg_w_rd,
    input  logic [XLEN-1:0]      reg_w_data,
    output logic                 wb_valid,
    output logic [REG_IDX_W-1:0] wb_rd,
    output logic [XLEN-1:0]      wb_data
);

    logic [1:0]                   req_size;

    logic                         ld_valid;
    logic [REG_IDX_W-1:0]         ld_rd;
    logic [OFF_W-1:0]             ld_off;
    logic [1:0]                   ld_size;
    logic                         ld_signed;

    logic                         rw_valid;
    logic [REG_IDX_W-1:0]         rw_rd;
    logic [XLEN-1:0]              rw_data;

    logic [LANES-1:0][BYTE_W-1:0] lane_bytes;
    mem_word_u                    rd_word;
    logic [BYTE_W-1:0]            sel_byte;
    logic [2*BYTE_W-1:0]          sel_half;
    logic [XLEN-1:0]              ld_data;

    // The access size follows from how many strobe bits are set.
    always_comb begin
        case ($countones(rd_req.strb))
            1:       req_size = SIZE_BYTE;
            2:       req_size = SIZE_HALF;
            default: req_size = SIZE_WORD;
        endcase
    end

    // Staged at the same edge that samples the bank read.
    always_ff @(posedge CLK) begin
        if (reset) begin
            ld_valid <= 1'b0;
            rw_valid <= 1'b0;
        end else begin
            ld_valid <= rd_req.valid;
            rw_valid <= (reg_w_rd != '0);
        end
    end

    always_ff @(posedge CLK) begin
        ld_rd     <= rd_req.rd;
        ld_off    <= rd_req.addr[OFF_W-1:0];
        ld_size   <= req_size;
        ld_signed <= rd_req.signed_ld;
        rw_rd     <= reg_w_rd;
        rw_data   <= reg_w_data;
    end

    for (genvar i = 0; i < LANES; i++) begin : g_gather
        assign lane_bytes[i] = bank[i].rdata;
    end

    assign rd_word.b = lane_bytes;

    // Halfwords are aligned, so the upper offset bit picks the half.
    assign sel_byte = rd_word.b[ld_off];
    assign sel_half = rd_word.h[ld_off[OFF_W-1]];

    always_comb begin
        case (ld_size)
            SIZE_BYTE: ld_data = {{(XLEN-BYTE_W){ld_signed & sel_byte[BYTE_W-1]}}, sel_byte};
            SIZE_HALF: ld_data = {{(XLEN-2*BYTE_W){ld_signed & sel_half[2*BYTE_W-1]}}, sel_half};
            default:   ld_data = rd_word;
        endcase
    end

    // A load wins over a register write staged in the same cycle.
    assign wb_valid = ld_valid | rw_valid;
    assign wb_rd    = ld_valid ? ld_rd : rw_rd;
    assign wb_data  = ld_valid ? ld_data : rw_data;

endmodule

// File: hdl/mem_stage_if.sv
`timescale 1ns/1ps

// Cushioned load request.
interface mem_rd_if import mem_stage_pkg::*; ();

    logic                 valid;
    logic [REG_IDX_W-1:0] rd;
    logic [ADDR_W-1:0]    addr;
    logic [LANES-1:0]     strb;
    logic                 signed_ld;

    modport source (output valid, output rd, output addr, output strb, output signed_ld);
    modport sink   (input valid, input rd, input addr, input strb, input signed_ld);

endinterface

// Cushioned store request. Data sits in the low bytes, strb in lane positions.
interface mem_wr_if import mem_stage_pkg::*; ();

    logic                 valid;
    logic [ADDR_W-1:0]    addr;
    logic [LANES-1:0]     strb;
    logic [XLEN-1:0]      data;

    modport source (output valid, output addr, output strb, output data);
    modport sink   (input valid, input addr, input strb, input data);

endinterface

// One byte-lane bank port.
interface bank_port_if import mem_stage_pkg::*; ();

    logic                 we;
    logic [BANK_AW-1:0]   waddr;
    logic [BYTE_W-1:0]    wdata;
    logic                 re;
    logic [BANK_AW-1:0]   raddr;
    logic [BYTE_W-1:0]    rdata;

    modport source (
        output we, output waddr, output wdata, output re, output raddr,
        input  rdata
    );
    modport sink (
        input  we, input waddr, input wdata, input re, input raddr,
        output rdata
    );
    // Read data only, for the load aligner.
    modport tap (input rdata);

endinterface

// File: hdl/mem_stage_pkg.sv
package mem_stage_pkg;

    // Datapath and register file widths.
    localparam int XLEN      = 32;
    localparam int ADDR_W    = 32;
    localparam int REG_IDX_W = 5;

    // Memory is split into byte lanes, one bank per lane.
    localparam int LANES      = 4;
    localparam int BYTE_W     = 8;
    localparam int OFF_W      = $clog2(LANES);
    localparam int BANK_DEPTH = 256;
    localparam int BANK_AW    = $clog2(BANK_DEPTH);

    // Access size codes, derived from the number of set strobe bits.
    localparam logic [1:0] SIZE_BYTE = 2'd0;
    localparam logic [1:0] SIZE_HALF = 2'd1;
    localparam logic [1:0] SIZE_WORD = 2'd2;

    // The word read back from the four banks.
    // Byte loads index it as bytes and halfword loads as halfwords.
    typedef union packed {
        logic [LANES-1:0][BYTE_W-1:0]       b;
        logic [LANES/2-1:0][2*BYTE_W-1:0]   h;
    } mem_word_u;

endpackage

// File: hdl/mem_stage_top.sv
`timescale 1ns/1ps

module mem_stage_top import mem_stage_pkg::*; (
    input  logic                 CLK,
    input  logic                 reset,

    input  logic [REG_IDX_W-1:0] exec_reg_w_rd,
    input  logic [XLEN-1:0]      exec_reg_w_data,

    input  logic                 exec_mem_r_valid,
    input  logic [REG_IDX_W-1:0] exec_mem_r_rd,
    input  logic [ADDR_W-1:0]    exec_mem_r_addr,
    input  logic [LANES-1:0]     exec_mem_r_strb,
    input  logic                 exec_mem_r_signed,

    input  logic                 exec_mem_w_valid,
    input  logic [ADDR_W-1:0]    exec_mem_w_addr,
    input  logic [LANES-1:0]     exec_mem_w_strb,
    input  logic [XLEN-1:0]      exec_mem_w_data,

    output logic                 wb_valid,
    output logic [REG_IDX_W-1:0] wb_rd,
    output logic [XLEN-1:0]      wb_data
);

    logic [REG_IDX_W-1:0] reg_w_rd;
    logic [XLEN-1:0]      reg_w_data;

    mem_rd_if    rd_req_if ();
    mem_wr_if    wr_req_if ();
    bank_port_if bank_if [LANES] ();

    cushion u_cushion (
        .CLK               (CLK),
        .reset             (reset),
        .exec_reg_w_rd     (exec_reg_w_rd),
        .exec_reg_w_data   (exec_reg_w_data),
        .exec_mem_r_valid  (exec_mem_r_valid),
        .exec_mem_r_rd     (exec_mem_r_rd),
        .exec_mem_r_addr   (exec_mem_r_addr),
        .exec_mem_r_strb   (exec_mem_r_strb),
        .exec_mem_r_signed (exec_mem_r_signed),
        .exec_mem_w_valid  (exec_mem_w_valid),
        .exec_mem_w_addr   (exec_mem_w_addr),
        .exec_mem_w_strb   (exec_mem_w_strb),
        .exec_mem_w_data   (exec_mem_w_data),
        .reg_w_rd          (reg_w_rd),
        .reg_w_data        (reg_w_data),
        .rd_req            (rd_req_if),
        .wr_req            (wr_req_if)
    );

    store_lane_steer u_store_lane_steer (
        .rd_req (rd_req_if),
        .wr_req (wr_req_if),
        .bank   (bank_if)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_bank
        byte_lane_ram u_byte_lane_ram (
            .CLK  (CLK),
            .port (bank_if[i])
        );
    end

    load_align u_load_align (
        .CLK        (CLK),
        .reset      (reset),
        .rd_req     (rd_req_if),
        .bank       (bank_if),
        .reg_w_rd   (reg_w_rd),
        .reg_w_data (reg_w_data),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

endmodule

// File: hdl/store_lane_steer.sv
`timescale 1ns/1ps

module store_lane_steer import mem_stage_pkg::*; (
    mem_rd_if.sink      rd_req,
    mem_wr_if.sink      wr_req,
    bank_port_if.source bank [LANES]
);

    logic [OFF_W-1:0]   wr_off;
    logic [XLEN-1:0]    wr_data_sh;
    logic [BANK_AW-1:0] wr_bank_addr;
    logic [BANK_AW-1:0] rd_bank_addr;

    // Store data arrives unshifted, so move it up to the lane of its first byte.
    assign wr_off     = wr_req.addr[OFF_W-1:0];
    assign wr_data_sh = wr_req.data << (wr_off * BYTE_W);

    // Word index inside a bank. Address bits above the bank range are dropped.
    assign wr_bank_addr = wr_req.addr[OFF_W +: BANK_AW];
    assign rd_bank_addr = rd_req.addr[OFF_W +: BANK_AW];

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        // A lane is written only where the store strobe selects it.
        assign bank[i].we    = wr_req.valid & wr_req.strb[i];
        assign bank[i].waddr = wr_bank_addr;
        assign bank[i].wdata = wr_data_sh[i*BYTE_W +: BYTE_W];

        // Loads read every lane, the aligner picks the bytes it needs.
        assign bank[i].re    = rd_req.valid;
        assign bank[i].raddr = rd_bank_addr;
    end

endmodule

// File: list.f
hdl/mem_stage_pkg.sv
hdl/mem_stage_if.sv
hdl/cushion.sv
hdl/store_lane_steer.sv
hdl/byte_lane_ram.sv
hdl/load_align.sv
hdl/mem_stage_top.sv
dv/mem_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the memory stage testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
    --top-module mem_stage_tb \
    -f list.f \
    -o mem_stage_sim \
    && ./obj_dir/mem_stage_sim \
    || exit 1
